// ==== logic/tcdm_config.svh ====
/*
  Width settings for the TCDM bank adapter
  Address, data word, byte enable and AMO operation code
*/
`ifndef TCDM_CONFIG_SVH
`define TCDM_CONFIG_SVH

// Byte address into the bank
`define TCDM_ADDR_WIDTH 32

// Data word, the AMO ALU is built for 32 bits only
`define TCDM_DATA_WIDTH 32

// One enable per byte of the data word
`define TCDM_BE_WIDTH 4

// Operation code carried on in_amo_i
`define TCDM_AMO_WIDTH 4

`endif

// ==== logic/tcdm_pkg.sv ====
/*
  Shared types of the TCDM bank adapter
  Address, data and byte enable words, AMO operation encoding
*/
`default_nettype none

`include "tcdm_config.svh"

package tcdm_pkg;

  // --------------------------------------------------------------------------
  // Bus words
  // --------------------------------------------------------------------------
  typedef logic [`TCDM_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`TCDM_DATA_WIDTH-1:0] data_t;
  typedef logic [`TCDM_BE_WIDTH-1:0]   be_t;

  // --------------------------------------------------------------------------
  // Atomic memory operations
  // --------------------------------------------------------------------------
  // Codes above AmoMinu are reserved and behave like AmoNone
  typedef enum logic [`TCDM_AMO_WIDTH-1:0] {
    AmoNone = 4'h0,
    AmoSwap = 4'h1,
    AmoAdd  = 4'h2,
    AmoAnd  = 4'h3,
    AmoOr   = 4'h4,
    AmoXor  = 4'h5,
    AmoMax  = 4'h6,
    AmoMaxu = 4'h7,
    AmoMin  = 4'h8,
    AmoMinu = 4'h9
  } amo_op_e;

endpackage

`default_nettype wire

// ==== logic/amo_alu.sv ====
/*
  Execute stage of the TCDM bank adapter
  AMO result from the old memory word and the request operand
*/
`default_nettype none

module amo_alu (
  input  tcdm_pkg::amo_op_e amo_op_i,
  input  tcdm_pkg::data_t   operand_a_i,
  input  tcdm_pkg::data_t   operand_b_i,
  output tcdm_pkg::data_t   result_o
);

  import tcdm_pkg::*;

  // Shared 33-bit adder, extra bit holds the comparison sign
  logic [32:0] adder_a;
  logic [32:0] adder_b;
  logic [32:0] adder_sum;
  logic        sub_en;
  logic        signed_cmp;
  logic        a_lt_b;

  // --------------------------------------------------------------------------
  // Adder and comparison
  // --------------------------------------------------------------------------
  assign sub_en     = amo_op_i inside {AmoMax, AmoMaxu, AmoMin, AmoMinu};
  assign signed_cmp = amo_op_i inside {AmoMax, AmoMin};

  // Sign extend for signed compares, zero extend otherwise
  assign adder_a = {signed_cmp & operand_a_i[31], operand_a_i};
  // Subtraction as a + ~b + 1
  assign adder_b = sub_en ? ~{signed_cmp & operand_b_i[31], operand_b_i}
                          : {1'b0, operand_b_i};
  assign adder_sum = adder_a + adder_b + {32'd0, sub_en};

  // Negative difference means the old word is the smaller one
  assign a_lt_b = adder_sum[32];

  // --------------------------------------------------------------------------
  // Result select
  // --------------------------------------------------------------------------
  always_comb begin
    unique case (amo_op_i)
      AmoSwap: result_o = operand_b_i;
      AmoAdd:  result_o = adder_sum[31:0];
      AmoAnd:  result_o = operand_a_i & operand_b_i;
      AmoOr:   result_o = operand_a_i | operand_b_i;
      AmoXor:  result_o = operand_a_i ^ operand_b_i;
      AmoMax,
      AmoMaxu: result_o = a_lt_b ? operand_b_i : operand_a_i;
      AmoMin,
      AmoMinu: result_o = a_lt_b ? operand_a_i : operand_b_i;
      // No operation leaves the word as it was
      default: result_o = operand_a_i;
    endcase
  end

  // Control only ever latches known codes
  always_comb begin
    op_known : assert #0 (!$isunknown(amo_op_i) && amo_op_i <= AmoMinu)
      else $error("Unknown AMO operation at the ALU");
  end

endmodule

`default_nettype wire

// ==== logic/tcdm_req_ctrl.sv ====
/*
  Request stage of the TCDM bank adapter
  Turns valid/ready requests into SRAM strobes, sequences the AMO
  write-back and flags returning read data for the response stage
*/
`default_nettype none

`include "tcdm_config.svh"

module tcdm_req_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Request port
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  input  tcdm_pkg::addr_t             in_address_i,
  input  logic [`TCDM_AMO_WIDTH-1:0]  in_amo_i,
  input  logic                        in_write_i,
  input  tcdm_pkg::data_t             in_wdata_i,
  input  tcdm_pkg::be_t               in_be_i,
  // Feedback from response and execute stages
  input  logic                        resp_stall_i,
  input  tcdm_pkg::data_t             amo_result_i,
  // SRAM port
  output logic                        out_req_o,
  output tcdm_pkg::addr_t             out_add_o,
  output logic                        out_write_o,
  output tcdm_pkg::data_t             out_wdata_o,
  output tcdm_pkg::be_t               out_be_o,
  // Response stage control
  output logic                        meta_push_o,
  output logic                        rdata_push_o,
  // Execute stage operands
  output tcdm_pkg::amo_op_e           amo_op_o,
  output tcdm_pkg::data_t             operand_b_o
);

  import tcdm_pkg::*;

  typedef enum logic {
    StIdle,
    StWriteBack
  } state_e;

  state_e  state_d, state_q;
  amo_op_e amo_in;
  logic    is_amo;
  logic    req_accepted;
  logic    amo_accepted;
  logic    rdata_push_q;

  // AMO context, captured at acceptance
  amo_op_e amo_op_q;
  addr_t   addr_q;
  data_t   operand_b_q;

  // --------------------------------------------------------------------------
  // Request handshake
  // --------------------------------------------------------------------------
  // Reserved codes fall out of the range and act as plain loads or stores
  assign amo_in       = amo_op_e'(in_amo_i);
  assign is_amo       = amo_in inside {[AmoSwap:AmoMinu]};

  // Blocked during write-back and while a response waits at the output
  assign in_ready_o   = (state_q == StIdle) & ~resp_stall_i;
  assign req_accepted = in_valid_i & in_ready_o;
  assign amo_accepted = req_accepted & is_amo;

  // Loads and AMOs both expect a response
  assign meta_push_o  = req_accepted & ~in_write_i;

  // --------------------------------------------------------------------------
  // SRAM drive and next state
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    // Feed-through by default
    out_req_o   = req_accepted;
    out_add_o   = in_address_i;
    out_write_o = in_write_i;
    out_wdata_o = in_wdata_i;
    out_be_o    = in_be_i;

    unique case (state_q)
      StIdle: begin
        // AMO read goes out now, write-back claims the next cycle
        if (amo_accepted) begin
          state_d = StWriteBack;
        end
      end
      StWriteBack: begin
        // Full-word write of the ALU result to the latched address
        out_req_o   = 1'b1;
        out_write_o = 1'b1;
        out_add_o   = addr_q;
        out_wdata_o = amo_result_i;
        out_be_o    = '1;
        state_d     = StIdle;
      end
      default: state_d = StIdle;
    endcase
  end

  // --------------------------------------------------------------------------
  // Registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= StIdle;
      amo_op_q     <= AmoNone;
      rdata_push_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      // Read data shows up one cycle after any read strobe
      rdata_push_q <= out_req_o & ~out_write_o;
      if (amo_accepted) begin
        amo_op_q <= amo_in;
      end
    end
  end

  // Address and operand only matter during write-back
  always_ff @(posedge clk_i) begin
    if (amo_accepted) begin
      addr_q      <= in_address_i;
      operand_b_q <= in_wdata_i;
    end
  end

  assign rdata_push_o = rdata_push_q;
  assign amo_op_o     = amo_op_q;
  assign operand_b_o  = operand_b_q;

  // --------------------------------------------------------------------------
  // Assertions
  // --------------------------------------------------------------------------
  // The cycle after an AMO belongs to the write-back
  amo_blocks_next : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    amo_accepted |=> !req_accepted)
    else $error("Request accepted during AMO write-back");

  // Write-back hits the word that was read
  amo_writes_back : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    amo_accepted |=> (out_req_o && out_write_o && out_add_o == $past(in_address_i)))
    else $error("AMO write-back missing or misdirected");

endmodule

`default_nettype wire

// ==== logic/tcdm_resp_buffer.sv ====
/*
  Response stage of the TCDM bank adapter
  Two-entry metadata spill buffer and a one-entry read data holding
  register, paired into a valid/ready response
*/
`default_nettype none

module tcdm_resp_buffer #(
  parameter type meta_t = logic
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  // From the request stage
  input  logic            meta_push_i,
  input  meta_t           meta_i,
  input  logic            rdata_push_i,
  input  tcdm_pkg::data_t rdata_i,
  // Response port
  output logic            in_valid_o,
  input  logic            in_ready_i,
  output tcdm_pkg::data_t in_rdata_o,
  output meta_t           in_meta_o,
  output logic            resp_stall_o
);

  import tcdm_pkg::*;

  // Metadata storage, circular over two slots
  meta_t      meta_mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       meta_valid;
  logic       meta_full;

  // Read data holding register
  data_t      data_q;
  logic       data_held_q;
  logic       data_valid;
  logic       data_capture;

  logic       resp_accepted;

  // --------------------------------------------------------------------------
  // Response output
  // --------------------------------------------------------------------------
  assign meta_valid    = (count_q != 2'd0);
  assign meta_full     = (count_q == 2'd2);
  assign data_valid    = data_held_q | rdata_push_i;

  // Data always trails its metadata, so both must be there
  assign in_valid_o    = meta_valid & data_valid;
  assign in_meta_o     = meta_mem_q[rd_ptr_q];
  // Fresh data bypasses the register when nothing is held
  assign in_rdata_o    = data_held_q ? data_q : rdata_i;

  assign resp_accepted = in_valid_o & in_ready_i;
  assign resp_stall_o  = in_valid_o & ~in_ready_i;

  // Keep incoming data unless it leaves right away
  assign data_capture  = rdata_push_i & ~(resp_accepted & ~data_held_q);

  // --------------------------------------------------------------------------
  // Control state
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q    <= 1'b0;
      rd_ptr_q    <= 1'b0;
      count_q     <= 2'd0;
      data_held_q <= 1'b0;
    end else begin
      if (meta_push_i) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (resp_accepted) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      unique case ({meta_push_i, resp_accepted})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
      data_held_q <= data_capture | (data_held_q & ~resp_accepted);
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (meta_push_i) begin
      meta_mem_q[wr_ptr_q] <= meta_i;
    end
    if (data_capture) begin
      data_q <= rdata_i;
    end
  end

  // --------------------------------------------------------------------------
  // Assertions
  // --------------------------------------------------------------------------
  // Request stage must stall before the metadata overflows
  meta_no_overflow : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    meta_push_i |-> !meta_full)
    else $error("Metadata pushed into a full buffer");

  // Held data must leave before the next read returns
  data_no_overwrite : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rdata_push_i |-> !data_held_q)
    else $error("Read data pushed while holding register occupied");

endmodule

`default_nettype wire

// ==== logic/tcdm_adapter.sv ====
/*
  TCDM bank adapter top level
  Request control, AMO execute and response buffer stages in front
  of a single-port SRAM
*/
`default_nettype none

`include "tcdm_config.svh"

module tcdm_adapter #(
  parameter type meta_t = logic
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Request port
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  tcdm_pkg::addr_t            in_address_i,
  input  logic [`TCDM_AMO_WIDTH-1:0] in_amo_i,
  input  logic                       in_write_i,
  input  tcdm_pkg::data_t            in_wdata_i,
  input  meta_t                      in_meta_i,
  input  tcdm_pkg::be_t              in_be_i,
  // Response port
  output logic                       in_valid_o,
  input  logic                       in_ready_i,
  output tcdm_pkg::data_t            in_rdata_o,
  output meta_t                      in_meta_o,
  // SRAM port
  output logic                       out_req_o,
  output tcdm_pkg::addr_t            out_add_o,
  output logic                       out_write_o,
  output tcdm_pkg::data_t            out_wdata_o,
  output tcdm_pkg::be_t              out_be_o,
  input  tcdm_pkg::data_t            out_rdata_i
);

  import tcdm_pkg::*;

  // Stage to stage wiring
  logic    meta_push;
  logic    rdata_push;
  logic    resp_stall;
  amo_op_e amo_op;
  data_t   operand_b;
  data_t   amo_result;

  // --------------------------------------------------------------------------
  // Request control
  // --------------------------------------------------------------------------
  tcdm_req_ctrl i_req_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_address_i (in_address_i),
    .in_amo_i     (in_amo_i),
    .in_write_i   (in_write_i),
    .in_wdata_i   (in_wdata_i),
    .in_be_i      (in_be_i),
    .resp_stall_i (resp_stall),
    .amo_result_i (amo_result),
    .out_req_o    (out_req_o),
    .out_add_o    (out_add_o),
    .out_write_o  (out_write_o),
    .out_wdata_o  (out_wdata_o),
    .out_be_o     (out_be_o),
    .meta_push_o  (meta_push),
    .rdata_push_o (rdata_push),
    .amo_op_o     (amo_op),
    .operand_b_o  (operand_b)
  );

  // Old word straight from the SRAM read port
  amo_alu i_amo_alu (
    .amo_op_i    (amo_op),
    .operand_a_i (out_rdata_i),
    .operand_b_i (operand_b),
    .result_o    (amo_result)
  );

  // --------------------------------------------------------------------------
  // Response buffering
  // --------------------------------------------------------------------------
  tcdm_resp_buffer #(
    .meta_t (meta_t)
  ) i_resp_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .meta_push_i  (meta_push),
    .meta_i       (in_meta_i),
    .rdata_push_i (rdata_push),
    .rdata_i      (out_rdata_i),
    .in_valid_o   (in_valid_o),
    .in_ready_i   (in_ready_i),
    .in_rdata_o   (in_rdata_o),
    .in_meta_o    (in_meta_o),
    .resp_stall_o (resp_stall)
  );

endmodule

`default_nettype wire

// ==== bench/sram_model.sv ====
/*
  Behavioral single-port SRAM for the adapter testbench
  256 words, byte enables, one-cycle read latency
*/
`default_nettype none

module sram_model (
  input  logic        clk_i,
  input  logic        req_i,
  input  logic        write_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  be_i,
  output logic [31:0] rdata_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Word array, indexed by address bits 9 to 2
  logic [31:0] mem [256];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        // Only enabled byte lanes change
        for (int b = 0; b < 4; b++) begin
          if (be_i[b]) begin
            mem[addr_i[9:2]][8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else begin
        // Read data valid in the next cycle
        rdata_o <= mem[addr_i[9:2]];
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_tcdm_adapter.sv ====
/*
  Testbench for the TCDM bank adapter
  Stores, loads and AMOs against a shadow memory, response scoreboard,
  protocol assertions, cycle timeout and summary
*/
`default_nettype none

`include "tcdm_config.svh"

module tb_tcdm_adapter;

  timeunit 1ns;
  timeprecision 1ps;

  import tcdm_pkg::*;

  // Preload, store/load, AMO sweep, random traffic, back-to-back loads
  localparam int NUM_OPS        = 16 + 12 + 27 + 40 + 8;
  localparam int TIMEOUT_CYCLES = 40 * NUM_OPS;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       in_valid_i;
  logic                       in_ready_o;
  addr_t                      in_address_i;
  logic [`TCDM_AMO_WIDTH-1:0] in_amo_i;
  logic                       in_write_i;
  data_t                      in_wdata_i;
  logic [7:0]                 in_meta_i;
  be_t                        in_be_i;
  logic                       in_valid_o;
  logic                       in_ready_i;
  data_t                      in_rdata_o;
  logic [7:0]                 in_meta_o;
  logic                       out_req_o;
  addr_t                      out_add_o;
  logic                       out_write_o;
  data_t                      out_wdata_o;
  be_t                        out_be_o;
  data_t                      out_rdata_i;

  integer     seed      = 54704;
  int         errors    = 0;
  int         cycles    = 0;
  string      test_name = "reset";
  logic       gaps_en   = 1'b0;
  logic [7:0] tag       = 8'd0;

  // Shadow memory and expected responses in request order
  data_t      shadow [256];
  data_t      exp_data_mem [256];
  logic [7:0] exp_tag_mem [256];
  int         push_cnt = 0;
  int         pop_cnt  = 0;
  data_t      head_data;
  logic [7:0] head_tag;

  logic req_accept;
  logic read_accept;
  logic amo_accept;
  logic resp_accept;

  assign req_accept  = in_valid_i & in_ready_o;
  assign read_accept = req_accept & ~in_write_i;
  assign amo_accept  = read_accept & (in_amo_i inside {[4'd1:4'd9]});
  assign resp_accept = in_valid_o & in_ready_i;
  assign head_data   = exp_data_mem[pop_cnt[7:0]];
  assign head_tag    = exp_tag_mem[pop_cnt[7:0]];

  tcdm_adapter #(
    .meta_t (logic [7:0])
  ) DUT (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_address_i (in_address_i),
    .in_amo_i     (in_amo_i),
    .in_write_i   (in_write_i),
    .in_wdata_i   (in_wdata_i),
    .in_meta_i    (in_meta_i),
    .in_be_i      (in_be_i),
    .in_valid_o   (in_valid_o),
    .in_ready_i   (in_ready_i),
    .in_rdata_o   (in_rdata_o),
    .in_meta_o    (in_meta_o),
    .out_req_o    (out_req_o),
    .out_add_o    (out_add_o),
    .out_write_o  (out_write_o),
    .out_wdata_o  (out_wdata_o),
    .out_be_o     (out_be_o),
    .out_rdata_i  (out_rdata_i)
  );

  sram_model i_sram (
    .clk_i   (clk_i),
    .req_i   (out_req_o),
    .write_i (out_write_o),
    .addr_i  (out_add_o),
    .wdata_i (out_wdata_o),
    .be_i    (out_be_o),
    .rdata_o (out_rdata_i)
  );

  // --------------------------------------------------------------------------
  // Clock, response ready and timeout
  // --------------------------------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Ready level picked at the edge and applied 1 ns later
  initial begin
    logic gap_ready;
    in_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      gap_ready = gaps_en ? (($random(seed) % 3) != 0) : 1'b1;
      #1;
      in_ready_i = gap_ready;
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout, run still busy after %0d cycles in %s", TIMEOUT_CYCLES, test_name);
      $display("TB FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Reference rules
  // --------------------------------------------------------------------------
  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t be);
    data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic data_t amo_apply(input amo_op_e op, input data_t old_w, input data_t opnd);
    case (op)
      AmoSwap: return opnd;
      AmoAdd:  return old_w + opnd;
      AmoAnd:  return old_w & opnd;
      AmoOr:   return old_w | opnd;
      AmoXor:  return old_w ^ opnd;
      AmoMax:  return ($signed(old_w) > $signed(opnd)) ? old_w : opnd;
      AmoMaxu: return (old_w > opnd) ? old_w : opnd;
      AmoMin:  return ($signed(old_w) < $signed(opnd)) ? old_w : opnd;
      AmoMinu: return (old_w < opnd) ? old_w : opnd;
      default: return old_w;
    endcase
  endfunction

  // Sampled mid-cycle while all inputs are settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (req_accept && in_write_i) begin
        shadow[in_address_i[9:2]] <=
          merge_bytes(shadow[in_address_i[9:2]], in_wdata_i, in_be_i);
      end
      if (read_accept) begin
        // Loads and AMOs both return the old word
        exp_data_mem[push_cnt[7:0]] <= shadow[in_address_i[9:2]];
        exp_tag_mem[push_cnt[7:0]]  <= in_meta_i;
        push_cnt <= push_cnt + 1;
      end
      if (amo_accept) begin
        shadow[in_address_i[9:2]] <=
          amo_apply(amo_op_e'(in_amo_i), shadow[in_address_i[9:2]], in_wdata_i);
      end
      if (resp_accept) pop_cnt <= pop_cnt + 1;
    end
  end

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  reset_idle : assert property (@(negedge clk_i)
    $rose(rst_ni) |-> (!out_req_o && !in_valid_o && in_ready_o))
    else begin
      errors++;
      $display("Outputs not idle after reset");
    end

  resp_data_ok : assert property (@(negedge clk_i) disable iff (!rst_ni)
    resp_accept |-> (in_rdata_o == head_data))
    else begin
      errors++;
      $display("[ERROR] %s: rdata expected %h actual %h", test_name,
               $sampled(head_data), $sampled(in_rdata_o));
    end

  resp_tag_ok : assert property (@(negedge clk_i) disable iff (!rst_ni)
    resp_accept |-> (in_meta_o == head_tag))
    else begin
      errors++;
      $display("[ERROR] %s: tag expected %h actual %h", test_name,
               $sampled(head_tag), $sampled(in_meta_o));
    end

  // No response without a request waiting for it
  resp_expected : assert property (@(negedge clk_i) disable iff (!rst_ni)
    in_valid_o |-> (push_cnt != pop_cnt))
    else begin
      errors++;
      $display("Response with no outstanding request in %s", test_name);
    end

  resp_held : assert property (@(negedge clk_i) disable iff (!rst_ni)
    (in_valid_o && !in_ready_i) |=>
      (in_valid_o && $stable(in_rdata_o) && $stable(in_meta_o)))
    else begin
      errors++;
      $display("Stalled response dropped or changed in %s", test_name);
    end

  stall_blocks : assert property (@(negedge clk_i) disable iff (!rst_ni)
    (in_valid_o && !in_ready_i) |-> !in_ready_o)
    else begin
      errors++;
      $display("Request port ready while response stalled in %s", test_name);
    end

  amo_ready_low : assert property (@(negedge clk_i) disable iff (!rst_ni)
    amo_accept |=> !in_ready_o)
    else begin
      errors++;
      $display("Request port ready during AMO write-back in %s", test_name);
    end

  read_latency : assert property (@(negedge clk_i) disable iff (!rst_ni)
    read_accept |=> in_valid_o)
    else begin
      errors++;
      $display("No response one cycle after accepted read in %s", test_name);
    end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  // Called 1 ns after a rising edge and returns 1 ns after the accepting edge
  task automatic send_req(input logic wr, input logic [3:0] amo, input logic [7:0] idx,
                          input data_t wd, input be_t be);
    logic accepted;
    accepted     = 1'b0;
    in_valid_i   = 1'b1;
    in_write_i   = wr;
    in_amo_i     = amo;
    in_address_i = {22'd0, idx, 2'b00};
    in_wdata_i   = wd;
    in_be_i      = be;
    in_meta_i    = tag;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = in_ready_o;
      @(posedge clk_i);
      #1;
    end
    in_valid_i = 1'b0;
    tag        = tag + 8'd1;
  endtask

  task automatic run_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Full words first so every later read hits known data
  task automatic preload_words();
    for (int i = 0; i < 16; i++) begin
      send_req(1'b1, 4'd0, i[7:0], $random(seed), 4'hf);
    end
  endtask

  task automatic store_then_load();
    logic [31:0] rnd;
    logic [7:0]  idx;
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      idx = {4'd0, rnd[3:0]};
      send_req(1'b1, 4'd0, idx, $random(seed), 4'hf);
      // Partial store merges with the word just written
      send_req(1'b1, 4'd0, idx, $random(seed), (rnd[7:4] == 4'h0) ? 4'h5 : rnd[7:4]);
      send_req(1'b0, 4'd0, idx, '0, 4'hf);
    end
  endtask

  task automatic sweep_amos();
    logic [31:0] rnd;
    logic [7:0]  idx;
    for (int op = 1; op <= 9; op++) begin
      test_name = $sformatf("amo_op_%0d", op);
      rnd = $random(seed);
      idx = {4'd0, rnd[3:0]};
      send_req(1'b1, 4'd0, idx, $random(seed), 4'hf);
      send_req(1'b0, op[3:0], idx, $random(seed), 4'hf);
      send_req(1'b0, 4'd0, idx, '0, 4'hf);
    end
  endtask

  task automatic random_traffic(input int n);
    logic [31:0] rnd;
    logic [7:0]  idx;
    logic [3:0]  amo;
    be_t         be;
    for (int i = 0; i < n; i++) begin
      rnd = $random(seed);
      idx = {4'd0, rnd[3:0]};
      be  = (rnd[11:8] == 4'h0) ? 4'hf : rnd[11:8];
      amo = (rnd[19:16] % 4'd9) + 4'd1;
      case (rnd[5:4])
        2'd0:    send_req(1'b1, 4'd0, idx, $random(seed), be);
        2'd1:    send_req(1'b0, amo, idx, $random(seed), 4'hf);
        default: send_req(1'b0, 4'd0, idx, '0, 4'hf);
      endcase
    end
  endtask

  initial begin
    rst_ni       = 1'b0;
    in_valid_i   = 1'b0;
    in_address_i = '0;
    in_amo_i     = '0;
    in_write_i   = 1'b0;
    in_wdata_i   = '0;
    in_meta_i    = '0;
    in_be_i      = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    run_cycles(1);

    test_name = "preload";
    preload_words();
    test_name = "store_load";
    store_then_load();
    sweep_amos();
    test_name = "ready_gaps";
    gaps_en = 1'b1;
    random_traffic(40);
    gaps_en = 1'b0;
    run_cycles(4);
    test_name = "back_to_back";
    for (int i = 0; i < 8; i++) begin
      send_req(1'b0, 4'd0, i[7:0], '0, 4'hf);
    end

    // Everything requested must have come back
    test_name = "drain";
    run_cycles(20);
    drained : assert (push_cnt == pop_cnt)
      else begin
        errors++;
        $display("%0d responses never returned", push_cnt - pop_cnt);
      end

    $display("Summary: %0d errors, %0d responses checked", errors, pop_cnt);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+logic
logic/tcdm_pkg.sv
logic/amo_alu.sv
logic/tcdm_req_ctrl.sv
logic/tcdm_resp_buffer.sv
logic/tcdm_adapter.sv
bench/sram_model.sv
bench/tb_tcdm_adapter.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the TCDM adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f vlog.f --top-module tb_tcdm_adapter -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
